/* Makefile */
# Verilator build and run of the peripheral bus testbench

SRCS := $(filter %.sv,$(shell cat ics_bus.f))

obj_dir/Vics_peripherals_tb: ics_bus.f $(SRCS) verilog/ics_bus_defs.svh tb/ics_tb_tasks.svh
	verilator --binary --timing --assert -Wno-fatal --timescale 1ns/1ps \
		--top-module ics_peripherals_tb -f ics_bus.f

run: obj_dir/Vics_peripherals_tb
	./obj_dir/Vics_peripherals_tb > sim.log 2>&1; cat sim.log
	@if grep -q "CHECKS FAILED" sim.log; then exit 1; fi
	@grep -q "ALL CHECKS PASSED" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: run clean

/* ics_bus.f */
+incdir+verilog
+incdir+tb
verilog/ics_bus_pkg.sv
verilog/ics_periph_pkg.sv
verilog/peripheral_bus_ctrl.sv
verilog/dsp_multiplier.sv
verilog/flash_pad_io.sv
verilog/ym_clock_enable.sv
verilog/ics_peripherals.sv
tb/ics_peripherals_tb.sv

/* tb/ics_tb_tasks.svh */
/*
 * Testbench bus and check tasks
 * Bus accesses with ready timing checks, and compares typed to the DUT
 */

task automatic compare_data(input string name, input ics_bus_pkg::bus_data_t got,
                            input ics_bus_pkg::bus_data_t exp);
    if (got !== exp) begin
        value_errors++;
        $display("ERROR: %s = 0x%08h, expected 0x%08h", name, got, exp);
    end
endtask

task automatic compare_product(input string name, input ics_periph_pkg::dsp_product_t got,
                               input ics_periph_pkg::dsp_product_t exp);
    if (got !== exp) begin
        value_errors++;
        $display("ERROR: %s = 0x%08h, expected 0x%08h", name, got, exp);
    end
endtask

task automatic compare_flash(input string name, input ics_periph_pkg::flash_ctrl_word_u got,
                             input ics_periph_pkg::flash_ctrl_word_u exp);
    if (got.raw !== exp.raw) begin
        value_errors++;
        $display("ERROR: %s = 0x%08h, expected 0x%08h", name, got.raw, exp.raw);
    end
endtask

// Counts rising edges until ready, sampled just after each edge
task automatic wait_ready(output int cycles);
    cycles = 0;
    while (!mem_ready && cycles < READY_TIMEOUT) begin
        @(posedge cpu_clk);
        #DRIVE_DELAY;
        cycles++;
    end
    if (!mem_ready) begin
        other_errors++;
        $display("Timeout: mem_ready never rose for address 0x%08h", mem_addr);
        end_run();
    end
endtask

// Holds the request through the ready cycle, drops valid on the next one
task automatic bus_access(input ics_bus_pkg::bus_addr_t addr,
                          input ics_bus_pkg::bus_wstrb_t wstrb,
                          input ics_bus_pkg::bus_data_t wdata,
                          output ics_bus_pkg::bus_data_t rdata);
    int cycles;
    @(posedge cpu_clk);
    #DRIVE_DELAY;
    mem_valid = 1'b1;
    mem_addr = addr;
    mem_wstrb = wstrb;
    mem_wdata = wdata;
    wait_ready(cycles);
    compare_data("mem_ready latency", 32'(cycles), 32'd2);
    rdata = mem_rdata;
    @(posedge cpu_clk);
    #DRIVE_DELAY;
    compare_data("mem_ready after pulse", {31'd0, mem_ready}, 32'd0);
    mem_valid = 1'b0;
    mem_wstrb = '0;
endtask

task automatic bus_write(input ics_bus_pkg::bus_addr_t addr,
                         input ics_bus_pkg::bus_data_t wdata);
    ics_bus_pkg::bus_data_t unused;
    bus_access(addr, 4'hF, wdata, unused);
endtask

task automatic bus_read(input ics_bus_pkg::bus_addr_t addr,
                        output ics_bus_pkg::bus_data_t rdata);
    bus_access(addr, 4'h0, 32'h0, rdata);
endtask

/* tb/ics_peripherals_tb.sv */
/*
 * Testbench for the peripheral bus block
 * Directed tests of bus timing, multiplier, gamepad, flash and audio ports
 */

`timescale 1ns/1ps

module ics_peripherals_tb;

    localparam time DRIVE_DELAY = 2;
    localparam int READY_TIMEOUT = 16;

    logic cpu_clk;
    logic cpu_reset;
    logic mem_valid;
    ics_bus_pkg::bus_addr_t mem_addr;
    ics_bus_pkg::bus_wstrb_t mem_wstrb;
    ics_bus_pkg::bus_data_t mem_wdata;
    logic [1:0] pad_data;
    logic user_button;
    logic [3:0] flash_out;
    ics_bus_pkg::bus_data_t mem_rdata;
    logic mem_ready;
    logic pad_latch;
    logic pad_clk;
    logic flash_clk;
    logic flash_csn;
    logic [3:0] flash_in;
    logic [3:0] flash_in_en;
    logic ym_cen;
    logic ym_cen_p1;
    logic ym_write_en;
    logic ym_write_address;
    logic [7:0] ym_write_data;

    int value_errors = 0;
    int other_errors = 0;
    integer seed = 10488;

    ics_peripherals ics_peripherals_i (.*);

    initial begin
        cpu_clk = 1'b0;
        forever #20 cpu_clk = ~cpu_clk;
    end

    task automatic end_run();
        $display("Errors: %0d wrong values, %0d other failures", value_errors, other_errors);
        if (value_errors == 0 && other_errors == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    endtask

    `include "ics_tb_tasks.svh"

    // Flash pins gathered into the control word layout
    function automatic ics_periph_pkg::flash_ctrl_word_u observed_flash_pins();
        ics_periph_pkg::flash_ctrl_word_u pins;
        pins.raw = '0;
        pins.fields.in = flash_in;
        pins.fields.in_en = flash_in_en;
        pins.fields.clk = flash_clk;
        pins.fields.csn = flash_csn;
        return pins;
    endfunction

    // Idle bus is clock low, inputs off, chip select high
    function automatic ics_periph_pkg::flash_ctrl_word_u expected_flash_pins(
            input ics_periph_pkg::flash_ctrl_word_u written);
        ics_periph_pkg::flash_ctrl_word_u pins;
        pins.raw = '0;
        pins.fields.csn = 1'b1;
        if (written.fields.active) begin
            pins.fields.in = written.fields.in;
            pins.fields.in_en = written.fields.in_en;
            pins.fields.clk = written.fields.clk;
            pins.fields.csn = written.fields.csn;
        end
        return pins;
    endfunction

    task automatic test_bus_timing();
        ics_bus_pkg::bus_data_t rdata;
        compare_data("{mem_ready, ym_cen, ym_cen_p1, ym_write_en, pad_latch, pad_clk}",
                     {26'd0, mem_ready, ym_cen, ym_cen_p1, ym_write_en, pad_latch, pad_clk},
                     32'd0);
        bus_write(32'h000F_0000, 32'hFFFF_FFFF);
        // Nonzero pad and flash inputs expose a read from the wrong block
        pad_data = 2'b11;
        user_button = 1'b1;
        flash_out = 4'hF;
        bus_read(32'h0009_0000, rdata);
        compare_data("unmapped mem_rdata", rdata, 32'd0);
        pad_data = 2'b00;
        user_button = 1'b0;
        flash_out = 4'h0;
    endtask

    task automatic test_multiplier();
        ics_periph_pkg::dsp_operand_t a;
        ics_periph_pkg::dsp_operand_t b;
        ics_periph_pkg::dsp_product_t expected;
        ics_bus_pkg::bus_data_t rdata;
        for (int i = 0; i < 10; i++) begin
            a = ics_periph_pkg::dsp_operand_t'($random(seed));
            b = ics_periph_pkg::dsp_operand_t'($random(seed));
            // Largest magnitudes first
            if (i == 0) begin
                a = -16'sd32768;
                b = -16'sd32768;
            end
            if (i == 1) begin
                a = -16'sd1;
                b = 16'sd32767;
            end
            expected = ics_periph_pkg::dsp_product_t'(int'(a) * int'(b));
            bus_write(32'h0001_0000, {16'h0000, a});
            bus_write(32'h0001_0004, {16'h0000, b});
            bus_read(32'h0001_0000, rdata);
            compare_product("dsp product", ics_periph_pkg::dsp_product_t'(rdata), expected);
        end
    endtask

    task automatic test_gamepad();
        ics_bus_pkg::bus_data_t rdata;
        bus_write(32'h0002_0000, 32'h0000_0001);
        compare_data("{pad_clk, pad_latch}", {30'd0, pad_clk, pad_latch}, 32'h1);
        bus_write(32'h0002_0000, 32'hFFFF_FFFE);
        compare_data("{pad_clk, pad_latch}", {30'd0, pad_clk, pad_latch}, 32'h2);
        pad_data = 2'b10;
        user_button = 1'b1;
        bus_read(32'h0002_0000, rdata);
        compare_data("pad mem_rdata", rdata, 32'h6);
        pad_data = 2'b01;
        user_button = 1'b0;
        bus_read(32'h0002_0000, rdata);
        compare_data("pad mem_rdata", rdata, 32'h1);
    endtask

    task automatic test_flash();
        ics_periph_pkg::flash_ctrl_word_u word;
        ics_bus_pkg::bus_data_t rdata;
        ics_bus_pkg::bus_data_t words [3] = '{32'h0000_81A5, 32'h0000_82F3, 32'hFFFF_7DFF};
        word.raw = '0;
        compare_flash("flash pins after reset", observed_flash_pins(), expected_flash_pins(word));
        foreach (words[i]) begin
            word.raw = words[i];
            bus_write(32'h0003_0000, word.raw);
            compare_flash("flash pins", observed_flash_pins(), expected_flash_pins(word));
        end
        flash_out = 4'h9;
        bus_read(32'h0003_0000, rdata);
        compare_data("flash mem_rdata", rdata, 32'h9);
    endtask

    task automatic test_prescaler();
        ics_bus_pkg::bus_data_t rdata;
        int cen_count;
        int p1_count;
        int write_count;
        cen_count = 0;
        p1_count = 0;
        write_count = 0;
        bus_read(32'h0004_0008, rdata);
        compare_data("prescaler after reset", rdata, 32'h0);
        bus_write(32'h0004_0008, 32'h4000_0000);
        // Quarter-rate enable expected from 2^30 out of 2^32
        for (int i = 0; i < 400; i++) begin
            @(negedge cpu_clk);
            if (ym_cen) cen_count++;
            if (ym_cen_p1) p1_count++;
            if (ym_write_en) write_count++;
        end
        if (cen_count < 98 || cen_count > 102 || write_count != 0) begin
            other_errors++;
            $display("%0d ym_cen pulses, %0d chip writes in 400 cycles; expected 98 to 102, none",
                     cen_count, write_count);
        end
        if (p1_count < cen_count / 2 - 1 || p1_count > cen_count / 2 + 1) begin
            other_errors++;
            $display("ym_cen_p1 pulsed %0d times against %0d ym_cen pulses", p1_count, cen_count);
        end
        bus_read(32'h0004_0008, rdata);
        compare_data("prescaler mem_rdata", rdata, 32'h4000_0000);
    endtask

    task automatic test_chip_write(input ics_bus_pkg::bus_addr_t addr,
                                   input ics_bus_pkg::bus_data_t data);
        int pulses;
        pulses = 0;
        bus_write(addr, data);
        for (int i = 0; i < 8; i++) begin
            @(negedge cpu_clk);
            if (ym_write_en) pulses++;
        end
        if (pulses != 1) begin
            other_errors++;
            $display("Chip write to 0x%08h gave %0d ym_write_en pulses instead of one",
                     addr, pulses);
        end
        compare_data("ym_write_data", {24'd0, ym_write_data}, {24'd0, data[7:0]});
        compare_data("ym_write_address", {31'd0, ym_write_address}, {31'd0, addr[2]});
    endtask

    initial begin
        cpu_reset = 1'b1;
        mem_valid = 1'b0;
        mem_addr = '0;
        mem_wstrb = '0;
        mem_wdata = '0;
        pad_data = 2'b00;
        user_button = 1'b0;
        flash_out = 4'h0;
        repeat (8) @(posedge cpu_clk);
        #DRIVE_DELAY;
        cpu_reset = 1'b0;
        test_bus_timing();
        test_flash();
        test_multiplier();
        test_gamepad();
        test_prescaler();
        test_chip_write(32'h0004_0000, 32'h0000_12A5);
        test_chip_write(32'h0004_0004, 32'h0000_345C);
        end_run();
    end

endmodule

/* verilog/dsp_multiplier.sv */
/*
 * DSP multiplier
 * Two signed 16-bit operand registers and a registered 32-bit product
 */

`timescale 1ns/1ps

module dsp_multiplier (
    input  logic                  cpu_clk,
    input  logic                  dsp_write_en,
    input  ics_bus_pkg::bus_addr_t mem_addr,
    input  ics_bus_pkg::bus_data_t mem_wdata,
    output ics_bus_pkg::bus_data_t dsp_rdata
);

    ics_periph_pkg::dsp_operand_t operand_a;
    ics_periph_pkg::dsp_operand_t operand_b;
    ics_periph_pkg::dsp_product_t product;

    // Address bit 2 picks operand B, otherwise operand A
    always_ff @(posedge cpu_clk) begin
        if (dsp_write_en && !mem_addr[2]) begin
            operand_a <= ics_periph_pkg::dsp_operand_t'(mem_wdata[15:0]);
        end

        if (dsp_write_en && mem_addr[2]) begin
            operand_b <= ics_periph_pkg::dsp_operand_t'(mem_wdata[15:0]);
        end

        // Product tracks the operands one cycle behind
        product <= operand_a * operand_b;
    end

    assign dsp_rdata = ics_bus_pkg::bus_data_t'(product);

endmodule

/* verilog/flash_pad_io.sv */
/*
 * Gamepad and flash control port
 * Gamepad latch/clock register and the CPU bit-bang flash control word
 */

`timescale 1ns/1ps

`include "ics_bus_defs.svh"

module flash_pad_io (
    input  logic                  cpu_clk,
    input  logic                  cpu_reset,
    input  logic                  pad_write_en,
    input  logic                  flash_write_en,
    input  ics_bus_pkg::bus_data_t mem_wdata,
    input  logic [1:0]            pad_data,
    input  logic                  user_button,
    input  logic [3:0]            flash_out,
    output ics_bus_pkg::bus_data_t pad_rdata,
    output ics_bus_pkg::bus_data_t flash_rdata,
    output logic                  pad_latch,
    output logic                  pad_clk,
    output logic                  flash_clk,
    output logic                  flash_csn,
    output logic [3:0]            flash_in,
    output logic [3:0]            flash_in_en
);

    logic [1:0] pad_ctrl;
    ics_periph_pkg::flash_ctrl_word_u flash_ctrl;

    always_ff @(posedge cpu_clk) begin
        if (cpu_reset) begin
            pad_ctrl <= 2'b00;
            flash_ctrl.raw <= `ICS_FLASH_CTRL_RESET;
        end else begin
            if (pad_write_en) begin
                pad_ctrl <= mem_wdata[1:0];
            end
            if (flash_write_en) begin
                flash_ctrl.raw <= mem_wdata;
            end
        end
    end

    assign pad_latch = pad_ctrl[0];
    assign pad_clk = pad_ctrl[1];

    // Idle flash bus unless the CPU holds control
    assign flash_clk = flash_ctrl.fields.active ? flash_ctrl.fields.clk : 1'b0;
    assign flash_csn = flash_ctrl.fields.active ? flash_ctrl.fields.csn : 1'b1;
    assign flash_in = flash_ctrl.fields.active ? flash_ctrl.fields.in : 4'h0;
    assign flash_in_en = flash_ctrl.fields.active ? flash_ctrl.fields.in_en : 4'h0;

    // flash_out comes from registered pads at the top of the chip
    assign pad_rdata = {{(`ICS_DATA_W-3){1'b0}}, user_button, pad_data};
    assign flash_rdata = {{(`ICS_DATA_W-4){1'b0}}, flash_out};

endmodule

/* verilog/ics_bus_defs.svh */
/*
 * Peripheral bus constants
 * Bus widths, the peripheral address map and register reset values
 */

`ifndef ICS_BUS_DEFS_SVH
`define ICS_BUS_DEFS_SVH

// Bus word sizes
`define ICS_DATA_W 32
`define ICS_ADDR_W 32

// Address bits that pick a peripheral region
`define ICS_REGION_LSB 16
`define ICS_REGION_MSB 19

`define ICS_REGION_DSP   4'd1
`define ICS_REGION_PAD   4'd2
`define ICS_REGION_FLASH 4'd3
`define ICS_REGION_AUDIO 4'd4

// Audio block sub-select, address bits 4..3
`define ICS_AUDIO_SEL_LSB       3
`define ICS_AUDIO_SEL_MSB       4
`define ICS_AUDIO_SEL_YM        2'd0
`define ICS_AUDIO_SEL_PRESCALER 2'd1

// Flash control word after reset: inactive, chip select high
`define ICS_FLASH_CTRL_RESET 32'h0000_0200
`define ICS_PRESCALER_RESET  32'h0000_0000

`endif

/* verilog/ics_bus_pkg.sv */
/*
 * Peripheral bus types
 * Address, data and strobe words of the CPU memory bus and the
 * decoded peripheral select
 */

`include "ics_bus_defs.svh"

package ics_bus_pkg;

    // Raw bus words
    typedef logic [`ICS_ADDR_W-1:0] bus_addr_t;
    typedef logic [`ICS_DATA_W-1:0] bus_data_t;

    // One strobe per byte lane
    typedef logic [`ICS_DATA_W/8-1:0] bus_wstrb_t;

    // Peripheral selected by the region field of an access
    typedef enum logic [2:0] {
        PERIPH_NONE  = 3'd0,
        PERIPH_DSP   = 3'd1,
        PERIPH_PAD   = 3'd2,
        PERIPH_FLASH = 3'd3,
        PERIPH_AUDIO = 3'd4
    } periph_sel_t;

endpackage

/* verilog/ics_periph_pkg.sv */
/*
 * Peripheral register types
 * Multiplier operands, the flash bit-bang control word and the
 * audio chip write latch
 */

package ics_periph_pkg;

    // Multiplier is signed only
    typedef logic signed [15:0] dsp_operand_t;
    typedef logic signed [31:0] dsp_product_t;

    // Flash control register as written by the CPU
    typedef struct packed {
        logic [15:0] reserved_hi;
        logic        active;
        logic [4:0]  reserved_lo;
        logic        csn;
        logic        clk;
        logic [3:0]  in_en;
        logic [3:0]  in;
    } flash_ctrl_fields_t;

    // Same word seen as raw bus data or as its fields
    typedef union packed {
        ics_bus_pkg::bus_data_t raw;
        flash_ctrl_fields_t     fields;
    } flash_ctrl_word_u;

    // Chip register write, laid out as {a0, data byte}
    typedef logic [8:0] ym_write_t;

endpackage

/* verilog/ics_peripherals.sv */
/*
 * Peripheral bus block
 * Bus controller with the multiplier, gamepad/flash port and audio
 * clock-enable blocks behind it
 */

`timescale 1ns/1ps

`include "ics_bus_defs.svh"

module ics_peripherals (
    input  logic                    cpu_clk,
    input  logic                    cpu_reset,
    input  logic                    mem_valid,
    input  logic [`ICS_ADDR_W-1:0]  mem_addr,
    input  logic [`ICS_DATA_W/8-1:0] mem_wstrb,
    input  logic [`ICS_DATA_W-1:0]  mem_wdata,
    input  logic [1:0]              pad_data,
    input  logic                    user_button,
    input  logic [3:0]              flash_out,
    output logic [`ICS_DATA_W-1:0]  mem_rdata,
    output logic                    mem_ready,
    output logic                    pad_latch,
    output logic                    pad_clk,
    output logic                    flash_clk,
    output logic                    flash_csn,
    output logic [3:0]              flash_in,
    output logic [3:0]              flash_in_en,
    output logic                    ym_cen,
    output logic                    ym_cen_p1,
    output logic                    ym_write_en,
    output logic                    ym_write_address,
    output logic [7:0]              ym_write_data
);

    logic dsp_write_en;
    logic pad_write_en;
    logic flash_write_en;
    logic audio_write_en;

    logic [`ICS_DATA_W-1:0] dsp_rdata;
    logic [`ICS_DATA_W-1:0] pad_rdata;
    logic [`ICS_DATA_W-1:0] flash_rdata;
    logic [`ICS_DATA_W-1:0] audio_rdata;

    peripheral_bus_ctrl peripheral_bus_ctrl_i (
        .cpu_clk(cpu_clk),
        .cpu_reset(cpu_reset),
        .mem_valid(mem_valid),
        .mem_addr(mem_addr),
        .mem_wstrb(mem_wstrb),
        .dsp_rdata(dsp_rdata),
        .pad_rdata(pad_rdata),
        .flash_rdata(flash_rdata),
        .audio_rdata(audio_rdata),
        .mem_ready(mem_ready),
        .mem_rdata(mem_rdata),
        .dsp_write_en(dsp_write_en),
        .pad_write_en(pad_write_en),
        .flash_write_en(flash_write_en),
        .audio_write_en(audio_write_en)
    );

    dsp_multiplier dsp_multiplier_i (
        .cpu_clk(cpu_clk),
        .dsp_write_en(dsp_write_en),
        .mem_addr(mem_addr),
        .mem_wdata(mem_wdata),
        .dsp_rdata(dsp_rdata)
    );

    flash_pad_io flash_pad_io_i (
        .cpu_clk(cpu_clk),
        .cpu_reset(cpu_reset),
        .pad_write_en(pad_write_en),
        .flash_write_en(flash_write_en),
        .mem_wdata(mem_wdata),
        .pad_data(pad_data),
        .user_button(user_button),
        .flash_out(flash_out),
        .pad_rdata(pad_rdata),
        .flash_rdata(flash_rdata),
        .pad_latch(pad_latch),
        .pad_clk(pad_clk),
        .flash_clk(flash_clk),
        .flash_csn(flash_csn),
        .flash_in(flash_in),
        .flash_in_en(flash_in_en)
    );

    ym_clock_enable ym_clock_enable_i (
        .cpu_clk(cpu_clk),
        .cpu_reset(cpu_reset),
        .audio_write_en(audio_write_en),
        .mem_addr(mem_addr),
        .mem_wdata(mem_wdata),
        .audio_rdata(audio_rdata),
        .ym_cen(ym_cen),
        .ym_cen_p1(ym_cen_p1),
        .ym_write_en(ym_write_en),
        .ym_write_address(ym_write_address),
        .ym_write_data(ym_write_data)
    );

endmodule

/* verilog/peripheral_bus_ctrl.sv */
/*
 * Peripheral bus controller
 * Decodes the peripheral region, runs the fixed two-cycle access,
 * pulses the write strobes and multiplexes the read data
 */

`timescale 1ns/1ps

`include "ics_bus_defs.svh"

module peripheral_bus_ctrl (
    input  logic                   cpu_clk,
    input  logic                   cpu_reset,
    input  logic                   mem_valid,
    input  ics_bus_pkg::bus_addr_t  mem_addr,
    input  ics_bus_pkg::bus_wstrb_t mem_wstrb,
    input  ics_bus_pkg::bus_data_t  dsp_rdata,
    input  ics_bus_pkg::bus_data_t  pad_rdata,
    input  ics_bus_pkg::bus_data_t  flash_rdata,
    input  ics_bus_pkg::bus_data_t  audio_rdata,
    output logic                   mem_ready,
    output ics_bus_pkg::bus_data_t  mem_rdata,
    output logic                   dsp_write_en,
    output logic                   pad_write_en,
    output logic                   flash_write_en,
    output logic                   audio_write_en
);

    ics_bus_pkg::periph_sel_t sel_decoded;
    ics_bus_pkg::periph_sel_t sel_q;
    logic access_q;
    logic is_write;
    logic start;

    // Region field to peripheral select
    always_comb begin
        case (mem_addr[`ICS_REGION_MSB:`ICS_REGION_LSB])
            `ICS_REGION_DSP:   sel_decoded = ics_bus_pkg::PERIPH_DSP;
            `ICS_REGION_PAD:   sel_decoded = ics_bus_pkg::PERIPH_PAD;
            `ICS_REGION_FLASH: sel_decoded = ics_bus_pkg::PERIPH_FLASH;
            `ICS_REGION_AUDIO: sel_decoded = ics_bus_pkg::PERIPH_AUDIO;
            default:           sel_decoded = ics_bus_pkg::PERIPH_NONE;
        endcase
    end

    // Any byte strobe makes it a full-word write
    assign is_write = |mem_wstrb;

    // Valid is still high on the ready cycle, so that one can't start an access
    assign start = mem_valid && !access_q && !mem_ready;

    always_ff @(posedge cpu_clk) begin
        if (cpu_reset) begin
            access_q <= 1'b0;
            sel_q <= ics_bus_pkg::PERIPH_NONE;
            mem_ready <= 1'b0;
            dsp_write_en <= 1'b0;
            pad_write_en <= 1'b0;
            flash_write_en <= 1'b0;
            audio_write_en <= 1'b0;
        end else begin
            access_q <= start;
            mem_ready <= access_q;

            if (start) begin
                sel_q <= sel_decoded;
            end

            // Strobes line up with mem_ready
            dsp_write_en <= access_q && is_write && (sel_q == ics_bus_pkg::PERIPH_DSP);
            pad_write_en <= access_q && is_write && (sel_q == ics_bus_pkg::PERIPH_PAD);
            flash_write_en <= access_q && is_write && (sel_q == ics_bus_pkg::PERIPH_FLASH);
            audio_write_en <= access_q && is_write && (sel_q == ics_bus_pkg::PERIPH_AUDIO);
        end
    end

    // Read word of the selected peripheral, zero when unmapped
    always_comb begin
        case (sel_q)
            ics_bus_pkg::PERIPH_DSP:   mem_rdata = dsp_rdata;
            ics_bus_pkg::PERIPH_PAD:   mem_rdata = pad_rdata;
            ics_bus_pkg::PERIPH_FLASH: mem_rdata = flash_rdata;
            ics_bus_pkg::PERIPH_AUDIO: mem_rdata = audio_rdata;
            default:                   mem_rdata = '0;
        endcase
    end

    // Ready is a single-cycle pulse per access
    ready_single_pulse: assert property (
        @(posedge cpu_clk) disable iff (cpu_reset) mem_ready |=> !mem_ready
    ) else $error("mem_ready high on two consecutive cycles");

    // Only one datapath block may see a write at once
    write_strobe_onehot: assert property (
        @(posedge cpu_clk) disable iff (cpu_reset)
        $onehot0({dsp_write_en, pad_write_en, flash_write_en, audio_write_en})
    ) else $error("more than one peripheral write strobe active");

endmodule

/* verilog/ym_clock_enable.sv */
/*
 * Audio chip clock enable and register write port
 * Fractional prescaler driving the chip clock enables, plus the latch
 * that holds one chip register write
 */

`timescale 1ns/1ps

`include "ics_bus_defs.svh"

module ym_clock_enable (
    input  logic                  cpu_clk,
    input  logic                  cpu_reset,
    input  logic                  audio_write_en,
    input  ics_bus_pkg::bus_addr_t mem_addr,
    input  ics_bus_pkg::bus_data_t mem_wdata,
    output ics_bus_pkg::bus_data_t audio_rdata,
    output logic                  ym_cen,
    output logic                  ym_cen_p1,
    output logic                  ym_write_en,
    output logic                  ym_write_address,
    output logic [7:0]            ym_write_data
);

    logic [1:0] sub_sel;
    logic ym_write;
    logic prescaler_write;
    ics_bus_pkg::bus_data_t prescaler;
    logic [32:0] fraction;
    logic [32:0] fraction_sum;
    logic tick;
    logic cen_p1_toggle;
    ics_periph_pkg::ym_write_t ym_write_q;

    assign sub_sel = mem_addr[`ICS_AUDIO_SEL_MSB:`ICS_AUDIO_SEL_LSB];
    assign ym_write = audio_write_en && (sub_sel == `ICS_AUDIO_SEL_YM);
    assign prescaler_write = audio_write_en && (sub_sel == `ICS_AUDIO_SEL_PRESCALER);

    assign audio_rdata = (sub_sel == `ICS_AUDIO_SEL_PRESCALER) ? prescaler : '0;

    assign fraction_sum = fraction + {1'b0, prescaler};

    // Bit 32 acts as the overflow flag and is consumed the cycle it is seen
    always_ff @(posedge cpu_clk) begin
        if (cpu_reset) begin
            prescaler <= `ICS_PRESCALER_RESET;
            fraction <= '0;
            tick <= 1'b0;
        end else begin
            if (prescaler_write) begin
                prescaler <= mem_wdata;
            end
            tick <= fraction[32];
            fraction <= {fraction[32] ? 1'b0 : fraction_sum[32], fraction_sum[31:0]};
        end
    end

    // Full-rate enable and the half-rate one for the second phase
    always_ff @(posedge cpu_clk) begin
        if (cpu_reset) begin
            ym_cen <= 1'b0;
            ym_cen_p1 <= 1'b0;
            cen_p1_toggle <= 1'b0;
        end else begin
            ym_cen <= tick;
            ym_cen_p1 <= tick && cen_p1_toggle;
            if (tick) begin
                cen_p1_toggle <= !cen_p1_toggle;
            end
        end
    end

    // Chip writes don't wait for a clock enable
    always_ff @(posedge cpu_clk) begin
        if (cpu_reset) begin
            ym_write_en <= 1'b0;
        end else begin
            ym_write_en <= ym_write;
        end
    end

    always_ff @(posedge cpu_clk) begin
        if (ym_write) begin
            ym_write_q <= {mem_addr[2], mem_wdata[7:0]};
        end
    end

    assign ym_write_address = ym_write_q[8];
    assign ym_write_data = ym_write_q[7:0];

    p1_within_cen: assert property (
        @(posedge cpu_clk) disable iff (cpu_reset) ym_cen_p1 |-> ym_cen
    ) else $error("ym_cen_p1 pulsed without ym_cen");

endmodule
